/* source/ex_pkg.sv */
package ex_pkg;

	localparam int xlen = 64;
	localparam int addr_width = 64;
	localparam int reg_addr_width = 5;

	typedef enum logic [4:0] {
		op_add   = 5'd0,
		op_addw  = 5'd1,
		op_sll   = 5'd2,
		op_sllw  = 5'd3,
		op_sra   = 5'd4,
		op_sraw  = 5'd5,
		op_srl   = 5'd6,
		op_srlw  = 5'd7,
		op_and   = 5'd8,
		op_or    = 5'd9,
		op_xor   = 5'd10,
		op_slt   = 5'd11,
		op_sltu  = 5'd12,
		op_seq   = 5'd13,
		op_sne   = 5'd14,
		op_sge   = 5'd15,
		op_sgeu  = 5'd16,
		op_sub   = 5'd17,
		op_subw  = 5'd18,
		op_mul   = 5'd19,
		op_mulh  = 5'd20,
		op_mulhu = 5'd21,
		op_mulw  = 5'd22,
		op_div   = 5'd23,
		op_divu  = 5'd24,
		op_divw  = 5'd25,
		op_divuw = 5'd26,
		op_rem   = 5'd27,
		op_remu  = 5'd28,
		op_remuw = 5'd29,
		op_remw  = 5'd30
	} alu_op_t;

	typedef struct packed {
		logic [addr_width-1:0]     pc;
		alu_op_t                   op;
		logic [xlen-1:0]           src_a;
		logic [xlen-1:0]           src_b;
		logic [xlen-1:0]           store_data;
		logic [11:0]               branch_imm; // in halfwords
		logic                      is_branch;
		logic                      mem_write;
		logic                      wb_from_mem;
		logic                      reg_write;
		logic [reg_addr_width-1:0] rd;
	} ex_in_t;

	typedef struct packed {
		logic [addr_width-1:0]     pc;
		logic [xlen-1:0]           result;
		logic [xlen-1:0]           store_data;
		logic                      mem_write;
		logic                      wb_from_mem;
		logic                      reg_write;
		logic [reg_addr_width-1:0] rd;
		logic                      branch_taken;
		logic [addr_width-1:0]     branch_target;
	} ex_out_t;

	typedef struct packed {
		logic [xlen-1:0] operand_a;
		logic [xlen-1:0] operand_b;
		logic            is_signed;
		logic            is_word;
	} unit_req_t;

endpackage

/* source/ex_alu.sv */
`timescale 1ns/100ps

module ex_alu (
	input  ex_pkg::alu_op_t                 op,
	input  logic [ex_pkg::xlen-1:0]         src_a,
	input  logic [ex_pkg::xlen-1:0]         src_b,
	input  logic [ex_pkg::addr_width-1:0]   pc,
	input  logic [11:0]                     branch_imm,
	output logic [ex_pkg::xlen-1:0]         alu_result,
	output logic [ex_pkg::addr_width-1:0]   branch_target
);

	logic        lt_s;
	logic        lt_u;
	logic        eq;
	logic        word;
	logic [31:0] word_res;

	function automatic logic [ex_pkg::xlen-1:0] zext_flag(input logic flag);
		return {{(ex_pkg::xlen-1){1'b0}}, flag};
	endfunction

	assign lt_s = $signed(src_a) < $signed(src_b);
	assign lt_u = src_a < src_b;
	assign eq   = src_a == src_b;

	// imm counts halfwords
	assign branch_target = pc + {{(ex_pkg::addr_width-13){branch_imm[11]}}, branch_imm, 1'b0};

	always_comb begin
		alu_result = '0; // mul/div and unused codes
		word_res   = '0;
		word       = 1'b0;
		case (op)
			ex_pkg::op_add:  alu_result = src_a + src_b;
			ex_pkg::op_sub:  alu_result = src_a - src_b;
			ex_pkg::op_sll:  alu_result = src_a << src_b[5:0];
			ex_pkg::op_srl:  alu_result = src_a >> src_b[5:0];
			ex_pkg::op_sra:  alu_result = $signed(src_a) >>> src_b[5:0];
			ex_pkg::op_and:  alu_result = src_a & src_b;
			ex_pkg::op_or:   alu_result = src_a | src_b;
			ex_pkg::op_xor:  alu_result = src_a ^ src_b;
			ex_pkg::op_slt:  alu_result = zext_flag(lt_s);
			ex_pkg::op_sltu: alu_result = zext_flag(lt_u);
			ex_pkg::op_seq:  alu_result = zext_flag(eq);
			ex_pkg::op_sne:  alu_result = zext_flag(!eq);
			ex_pkg::op_sge:  alu_result = zext_flag(!lt_s);
			ex_pkg::op_sgeu: alu_result = zext_flag(!lt_u);
			ex_pkg::op_addw: begin
				word_res = src_a[31:0] + src_b[31:0];
				word     = 1'b1;
			end
			ex_pkg::op_subw: begin
				word_res = src_a[31:0] - src_b[31:0];
				word     = 1'b1;
			end
			ex_pkg::op_sllw: begin
				word_res = src_a[31:0] << src_b[4:0];
				word     = 1'b1;
			end
			ex_pkg::op_srlw: begin
				word_res = src_a[31:0] >> src_b[4:0];
				word     = 1'b1;
			end
			ex_pkg::op_sraw: begin
				word_res = $signed(src_a[31:0]) >>> src_b[4:0];
				word     = 1'b1;
			end
			default: alu_result = '0;
		endcase
		if (word) begin
			alu_result = {{(ex_pkg::xlen-32){word_res[31]}}, word_res};
		end
	end

endmodule

/* source/ex_mul_unit.sv */
`timescale 1ns/100ps

module ex_mul_unit #(
	parameter int data_width = 64
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    start,
	input  ex_pkg::unit_req_t       req,
	input  logic                    high,
	output logic                    done,
	output logic [data_width-1:0]   product
);

	localparam int cnt_width = $clog2(data_width + 1);

	logic                      busy;
	logic [cnt_width-1:0]      cnt;
	logic [2*data_width-1:0]   acc_q;   // {partial sum, multiplier}
	logic [data_width-1:0]     mcand_q;
	logic                      neg_q;
	logic                      high_q;
	logic                      word_q;
	logic [data_width-1:0]     a_in;
	logic [data_width-1:0]     b_in;
	logic                      a_neg;
	logic                      b_neg;
	logic [data_width:0]       step_sum;
	logic [2*data_width-1:0]   full;

	assign a_in  = req.operand_a[data_width-1:0];
	assign b_in  = req.operand_b[data_width-1:0];
	assign a_neg = req.is_signed & a_in[data_width-1];
	assign b_neg = req.is_signed & b_in[data_width-1];

	assign step_sum = {1'b0, acc_q[2*data_width-1:data_width]}
		+ (acc_q[0] ? {1'b0, mcand_q} : '0);
	assign full = neg_q ? -acc_q : acc_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			cnt  <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				cnt  <= '0;
			end else if (busy) begin
				if (cnt == cnt_width'(data_width)) begin
					busy <= 1'b0; // sign fix cycle
					done <= 1'b1;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			acc_q   <= {{data_width{1'b0}}, (b_neg ? -b_in : b_in)};
			mcand_q <= a_neg ? -a_in : a_in;
			neg_q   <= a_neg ^ b_neg;
			high_q  <= high;
			word_q  <= req.is_word;
		end else if (busy && cnt != cnt_width'(data_width)) begin
			acc_q <= {step_sum, acc_q[data_width-1:1]};
		end else if (busy) begin
			if (high_q)
				product <= full[2*data_width-1:data_width];
			else if (word_q)
				product <= {{(data_width-32){full[31]}}, full[31:0]};
			else
				product <= full[data_width-1:0];
		end
	end

	a_start_idle: assert property (@(posedge clk) disable iff (reset) start |-> !busy);

endmodule

/* source/ex_div_unit.sv */
`timescale 1ns/100ps

module ex_div_unit #(
	parameter int data_width = 64
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    start,
	input  ex_pkg::unit_req_t       req,
	input  logic                    want_rem,
	output logic                    done,
	output logic [data_width-1:0]   value
);

	localparam int cnt_width = $clog2(data_width + 1);

	logic                    busy;
	logic [cnt_width-1:0]    cnt;
	logic [data_width-1:0]   rem_q;
	logic [data_width-1:0]   quo_q;   // dividend shifts out, quotient shifts in
	logic [data_width-1:0]   dvs_q;
	logic [data_width-1:0]   dvd_q;   // extended dividend for corner cases
	logic                    neg_q;
	logic                    neg_r;
	logic                    zero_q;
	logic                    ovf_q;
	logic                    word_q;
	logic                    rem_sel;
	logic [data_width-1:0]   a_ext;
	logic [data_width-1:0]   b_ext;
	logic                    a_neg;
	logic                    b_neg;
	logic                    a_min;
	logic [data_width:0]     shifted;
	logic                    fits;
	logic [data_width-1:0]   q_fix;
	logic [data_width-1:0]   r_fix;
	logic [data_width-1:0]   res;

	assign a_ext = req.is_word
		? {{(data_width-32){req.is_signed & req.operand_a[31]}}, req.operand_a[31:0]}
		: req.operand_a[data_width-1:0];
	assign b_ext = req.is_word
		? {{(data_width-32){req.is_signed & req.operand_b[31]}}, req.operand_b[31:0]}
		: req.operand_b[data_width-1:0];
	assign a_neg = req.is_signed & a_ext[data_width-1];
	assign b_neg = req.is_signed & b_ext[data_width-1];
	assign a_min = req.is_word ? (req.operand_a[31:0] == 32'h8000_0000)
		: (a_ext == {1'b1, {(data_width-1){1'b0}}});

	assign shifted = {rem_q, quo_q[data_width-1]};
	assign fits    = shifted >= {1'b0, dvs_q};

	always_comb begin
		q_fix = neg_q ? -quo_q : quo_q;
		r_fix = neg_r ? -rem_q : rem_q;
		if (zero_q) begin
			q_fix = '1;
			r_fix = dvd_q;
		end else if (ovf_q) begin
			q_fix = dvd_q;
			r_fix = '0;
		end
		res = rem_sel ? r_fix : q_fix;
		if (word_q) begin
			res = {{(data_width-32){res[31]}}, res[31:0]};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			cnt  <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				cnt  <= '0;
			end else if (busy) begin
				if (cnt == cnt_width'(data_width)) begin
					busy <= 1'b0;
					done <= 1'b1;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			rem_q   <= '0;
			quo_q   <= a_neg ? -a_ext : a_ext;
			dvs_q   <= b_neg ? -b_ext : b_ext;
			dvd_q   <= a_ext;
			neg_q   <= a_neg ^ b_neg;
			neg_r   <= a_neg; // remainder follows dividend
			zero_q  <= b_ext == '0;
			ovf_q   <= req.is_signed & a_min & (b_ext == '1);
			word_q  <= req.is_word;
			rem_sel <= want_rem;
		end else if (busy && cnt != cnt_width'(data_width)) begin
			rem_q <= fits ? shifted[data_width-1:0] - dvs_q : shifted[data_width-1:0];
			quo_q <= {quo_q[data_width-2:0], fits};
		end else if (busy) begin
			value <= res;
		end
	end

	a_start_idle: assert property (@(posedge clk) disable iff (reset) start |-> !busy);

endmodule

/* source/ex_sequencer.sv */
`timescale 1ns/100ps

module ex_sequencer (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            in_valid,
	output logic                            in_ready,
	input  ex_pkg::ex_in_t                  in_data,
	input  logic [ex_pkg::xlen-1:0]         alu_result,
	input  logic [ex_pkg::addr_width-1:0]   branch_target,
	output logic                            mul_start,
	output ex_pkg::unit_req_t               mul_req,
	output logic                            mul_high,
	input  logic                            mul_done,
	input  logic [ex_pkg::xlen-1:0]         mul_product,
	output logic                            div_start,
	output ex_pkg::unit_req_t               div_req,
	output logic                            div_want_rem,
	input  logic                            div_done,
	input  logic [ex_pkg::xlen-1:0]         div_value,
	output logic                            out_valid,
	input  logic                            out_ready,
	output ex_pkg::ex_out_t                 out_data
);

	logic                            pending;
	logic                            accept;
	logic                            in_mul;
	logic                            in_div;
	ex_pkg::ex_in_t                  hold_q;
	logic [ex_pkg::addr_width-1:0]   hold_target;
	ex_pkg::alu_op_t                 hold_op;
	ex_pkg::unit_req_t               req;

	function automatic ex_pkg::ex_out_t make_out(
		input ex_pkg::ex_in_t                d,
		input logic [ex_pkg::xlen-1:0]       result,
		input logic [ex_pkg::addr_width-1:0] target
	);
		ex_pkg::ex_out_t o;
		o.pc            = d.pc;
		o.result        = result;
		o.store_data    = d.store_data;
		o.mem_write     = d.mem_write;
		o.wb_from_mem   = d.wb_from_mem;
		o.reg_write     = d.reg_write;
		o.rd            = d.rd;
		o.branch_taken  = d.is_branch && (result != '0);
		o.branch_target = target;
		return o;
	endfunction

	assign in_mul   = in_data.op >= ex_pkg::op_mul && in_data.op <= ex_pkg::op_mulw;
	assign in_div   = in_data.op >= ex_pkg::op_div && in_data.op <= ex_pkg::op_remw;
	assign in_ready = !pending && (!out_valid || out_ready);
	assign accept   = in_valid && in_ready;

	// unit request decoded from the held item
	assign hold_op       = hold_q.op;
	assign req.operand_a = hold_q.src_a;
	assign req.operand_b = hold_q.src_b;
	assign req.is_signed = hold_op inside {ex_pkg::op_mulh, ex_pkg::op_mulw, ex_pkg::op_div,
		ex_pkg::op_divw, ex_pkg::op_rem, ex_pkg::op_remw};
	assign req.is_word   = hold_op inside {ex_pkg::op_mulw, ex_pkg::op_divw, ex_pkg::op_divuw,
		ex_pkg::op_remuw, ex_pkg::op_remw};
	assign mul_req       = req;
	assign div_req       = req;
	assign mul_high      = hold_op inside {ex_pkg::op_mulh, ex_pkg::op_mulhu};
	assign div_want_rem  = hold_op >= ex_pkg::op_rem;

	always_ff @(posedge clk) begin
		if (reset) begin
			pending   <= 1'b0;
			mul_start <= 1'b0;
			div_start <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			mul_start <= accept && in_mul;
			div_start <= accept && in_div;
			if (accept && (in_mul || in_div))
				pending <= 1'b1;
			else if (mul_done || div_done)
				pending <= 1'b0;
			if ((accept && !in_mul && !in_div) || mul_done || div_done)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept && (in_mul || in_div)) begin
			hold_q      <= in_data;
			hold_target <= branch_target;
		end
		if (accept && !in_mul && !in_div)
			out_data <= make_out(in_data, alu_result, branch_target);
		else if (mul_done)
			out_data <= make_out(hold_q, mul_product, hold_target);
		else if (div_done)
			out_data <= make_out(hold_q, div_value, hold_target);
	end

	a_out_hold: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

/* source/ex_stage.sv */
`timescale 1ns/100ps

module ex_stage (
	input  logic              clk,
	input  logic              reset,
	input  logic              in_valid,
	output logic              in_ready,
	input  ex_pkg::ex_in_t    in_data,
	output logic              out_valid,
	input  logic              out_ready,
	output ex_pkg::ex_out_t   out_data
);

	logic [ex_pkg::xlen-1:0]         alu_result;
	logic [ex_pkg::addr_width-1:0]   branch_target;
	logic                            mul_start;
	ex_pkg::unit_req_t               mul_req;
	logic                            mul_high;
	logic                            mul_done;
	logic [ex_pkg::xlen-1:0]         mul_product;
	logic                            div_start;
	ex_pkg::unit_req_t               div_req;
	logic                            div_want_rem;
	logic                            div_done;
	logic [ex_pkg::xlen-1:0]         div_value;

	ex_alu alu_i (
		.op            (in_data.op),
		.src_a         (in_data.src_a),
		.src_b         (in_data.src_b),
		.pc            (in_data.pc),
		.branch_imm    (in_data.branch_imm),
		.alu_result    (alu_result),
		.branch_target (branch_target)
	);

	ex_mul_unit #(.data_width(ex_pkg::xlen)) mul_i (
		.clk     (clk),
		.reset   (reset),
		.start   (mul_start),
		.req     (mul_req),
		.high    (mul_high),
		.done    (mul_done),
		.product (mul_product)
	);

	ex_div_unit #(.data_width(ex_pkg::xlen)) div_i (
		.clk      (clk),
		.reset    (reset),
		.start    (div_start),
		.req      (div_req),
		.want_rem (div_want_rem),
		.done     (div_done),
		.value    (div_value)
	);

	ex_sequencer seq_i (
		.clk           (clk),
		.reset         (reset),
		.in_valid      (in_valid),
		.in_ready      (in_ready),
		.in_data       (in_data),
		.alu_result    (alu_result),
		.branch_target (branch_target),
		.mul_start     (mul_start),
		.mul_req       (mul_req),
		.mul_high      (mul_high),
		.mul_done      (mul_done),
		.mul_product   (mul_product),
		.div_start     (div_start),
		.div_req       (div_req),
		.div_want_rem  (div_want_rem),
		.div_done      (div_done),
		.div_value     (div_value),
		.out_valid     (out_valid),
		.out_ready     (out_ready),
		.out_data      (out_data)
	);

endmodule

/* testbench/ex_ref.svh */
`ifndef ex_ref_svh
`define ex_ref_svh

function automatic logic [63:0] sign_extend_word(input logic [31:0] w);
	return {{32{w[31]}}, w};
endfunction

// RISC-V division with the zero divisor and signed overflow cases first
function automatic logic [63:0] divide_rule(input logic [63:0] a, input logic [63:0] b,
		input logic sgn, input logic word, input logic rem);
	logic signed [63:0] sa;
	logic signed [63:0] sb;
	logic signed [31:0] wa;
	logic signed [31:0] wb;
	logic [63:0]        q;
	logic [63:0]        r;
	sa = a;
	sb = b;
	wa = a[31:0];
	wb = b[31:0];
	if (word) begin
		if (b[31:0] == 32'd0) begin
			q = '1;
			r = sign_extend_word(a[31:0]);
		end else if (sgn && a[31:0] == 32'h8000_0000 && b[31:0] == 32'hffff_ffff) begin
			q = sign_extend_word(a[31:0]);
			r = '0;
		end else if (sgn) begin
			q = sign_extend_word(wa / wb);
			r = sign_extend_word(wa % wb);
		end else begin
			q = sign_extend_word(a[31:0] / b[31:0]);
			r = sign_extend_word(a[31:0] % b[31:0]);
		end
	end else begin
		if (b == 64'd0) begin
			q = '1;
			r = a;
		end else if (sgn && a == 64'h8000_0000_0000_0000 && b == '1) begin
			q = a;
			r = '0;
		end else if (sgn) begin
			q = sa / sb;
			r = sa % sb;
		end else begin
			q = a / b;
			r = a % b;
		end
	end
	return rem ? r : q;
endfunction

function automatic logic [63:0] ref_result(input ex_pkg::ex_in_t d);
	logic [63:0]  a;
	logic [63:0]  b;
	logic [127:0] prod_s;
	logic [127:0] prod_u;
	logic         lt_s;
	logic [63:0]  r;
	a = d.src_a;
	b = d.src_b;
	prod_s = {{64{a[63]}}, a} * {{64{b[63]}}, b};
	prod_u = {64'd0, a} * {64'd0, b};
	lt_s = (a[63] != b[63]) ? a[63] : (a < b); // sign bits decide first
	case (d.op)
		ex_pkg::op_add:   r = a + b;
		ex_pkg::op_addw:  r = sign_extend_word(a[31:0] + b[31:0]);
		ex_pkg::op_sll:   r = a << b[5:0];
		ex_pkg::op_sllw:  r = sign_extend_word(a[31:0] << b[4:0]);
		ex_pkg::op_sra:   r = (a >> b[5:0])
			| (a[63] ? ~(64'hffff_ffff_ffff_ffff >> b[5:0]) : 64'd0);
		ex_pkg::op_sraw:  r = sign_extend_word((a[31:0] >> b[4:0])
			| (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'd0));
		ex_pkg::op_srl:   r = a >> b[5:0];
		ex_pkg::op_srlw:  r = sign_extend_word(a[31:0] >> b[4:0]);
		ex_pkg::op_and:   r = a & b;
		ex_pkg::op_or:    r = a | b;
		ex_pkg::op_xor:   r = a ^ b;
		ex_pkg::op_slt:   r = 64'(lt_s);
		ex_pkg::op_sltu:  r = 64'(a < b);
		ex_pkg::op_seq:   r = 64'(a == b);
		ex_pkg::op_sne:   r = 64'(a != b);
		ex_pkg::op_sge:   r = 64'(!lt_s);
		ex_pkg::op_sgeu:  r = 64'(!(a < b));
		ex_pkg::op_sub:   r = a - b;
		ex_pkg::op_subw:  r = sign_extend_word(a[31:0] - b[31:0]);
		ex_pkg::op_mul:   r = prod_u[63:0];
		ex_pkg::op_mulh:  r = prod_s[127:64];
		ex_pkg::op_mulhu: r = prod_u[127:64];
		ex_pkg::op_mulw:  r = sign_extend_word(prod_u[31:0]);
		ex_pkg::op_div:   r = divide_rule(a, b, 1'b1, 1'b0, 1'b0);
		ex_pkg::op_divu:  r = divide_rule(a, b, 1'b0, 1'b0, 1'b0);
		ex_pkg::op_divw:  r = divide_rule(a, b, 1'b1, 1'b1, 1'b0);
		ex_pkg::op_divuw: r = divide_rule(a, b, 1'b0, 1'b1, 1'b0);
		ex_pkg::op_rem:   r = divide_rule(a, b, 1'b1, 1'b0, 1'b1);
		ex_pkg::op_remu:  r = divide_rule(a, b, 1'b0, 1'b0, 1'b1);
		ex_pkg::op_remuw: r = divide_rule(a, b, 1'b0, 1'b1, 1'b1);
		ex_pkg::op_remw:  r = divide_rule(a, b, 1'b1, 1'b1, 1'b1);
		default:          r = '0;
	endcase
	return r;
endfunction

function automatic ex_pkg::ex_out_t ex_ref(input ex_pkg::ex_in_t d);
	ex_pkg::ex_out_t o;
	o.pc            = d.pc;
	o.result        = ref_result(d);
	o.store_data    = d.store_data;
	o.mem_write     = d.mem_write;
	o.wb_from_mem   = d.wb_from_mem;
	o.reg_write     = d.reg_write;
	o.rd            = d.rd;
	o.branch_taken  = d.is_branch && (o.result != 64'd0);
	o.branch_target = d.pc + ({{52{d.branch_imm[11]}}, d.branch_imm} << 1); // halfwords
	return o;
endfunction

`endif

/* testbench/ex_stage_tb.sv */
`timescale 1ns/100ps

module ex_stage_tb;

	localparam int clk_period = 4;
	localparam int n_alu      = 120;
	localparam int n_mul      = 24;
	localparam int n_div      = 52; // 12 corner items, 40 random
	localparam int n_branch   = 20;
	localparam int n_mixed    = 80;
	localparam int n_items    = n_alu + n_mul + n_div + n_branch + n_mixed;

	logic            clk = 1'b0;
	logic            reset;
	logic            in_valid;
	logic            in_ready;
	ex_pkg::ex_in_t  in_data;
	logic            out_valid;
	logic            out_ready = 1'b1;
	ex_pkg::ex_out_t out_data;

	logic            ready_random = 1'b0;
	logic            ready_pattern [0:1023];
	int              ready_idx = 0;
	ex_pkg::ex_in_t  exp_q [$];
	int              acc_q [$];
	int              sample = 0;
	int              first_seen = 0;
	logic            shown = 1'b0;
	logic            unit_wait = 1'b0; // mul/div accepted, result not yet shown
	logic            held = 1'b0;
	ex_pkg::ex_out_t held_data;
	int              errors = 0;
	int              checked = 0;

	`include "ex_ref.svh"

	ex_stage ex_stage_i (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

	always #(clk_period / 2) clk = ~clk;

	always @(negedge clk) begin
		out_ready = ready_random ? ready_pattern[ready_idx % 1024] : 1'b1;
		ready_idx = ready_idx + 1;
	end

	function automatic logic [63:0] rand_operand();
		case ($urandom % 8)
			0:       return 64'd0;
			1:       return '1;
			2:       return 64'h8000_0000_0000_0000;
			3:       return 64'($urandom % 17);
			4:       return -64'($urandom % 17);
			5:       return {$urandom, 32'hffff_ffff};
			default: return {$urandom, $urandom};
		endcase
	endfunction

	function automatic ex_pkg::ex_in_t make_item(input ex_pkg::alu_op_t op);
		ex_pkg::ex_in_t d;
		d.pc          = {$urandom, $urandom};
		d.op          = op;
		d.src_a       = rand_operand();
		d.src_b       = rand_operand();
		d.store_data  = {$urandom, $urandom};
		d.branch_imm  = 12'($urandom);
		d.is_branch   = ($urandom % 4) == 0;
		d.mem_write   = 1'($urandom);
		d.wb_from_mem = 1'($urandom);
		d.reg_write   = 1'($urandom);
		d.rd          = 5'($urandom);
		return d;
	endfunction

	task automatic check_field(input string name, input logic [63:0] exp_v,
			input logic [63:0] act_v);
		if (act_v !== exp_v) begin
			errors++;
			$display("[FAIL] %s: expected %h, got %h", name, exp_v, act_v);
		end
	endtask

	task automatic check_output();
		ex_pkg::ex_in_t  d;
		ex_pkg::ex_out_t e;
		int              acc;
		if (exp_q.size() == 0) begin
			errors++;
			$display("an output was transferred with no item outstanding");
		end else begin
			d = exp_q.pop_front();
			acc = acc_q.pop_front();
			e = ex_ref(d);
			check_field("pc", e.pc, out_data.pc);
			check_field("result", e.result, out_data.result);
			check_field("store_data", e.store_data, out_data.store_data);
			check_field("mem_write", 64'(e.mem_write), 64'(out_data.mem_write));
			check_field("wb_from_mem", 64'(e.wb_from_mem), 64'(out_data.wb_from_mem));
			check_field("reg_write", 64'(e.reg_write), 64'(out_data.reg_write));
			check_field("rd", 64'(e.rd), 64'(out_data.rd));
			check_field("branch_taken", 64'(e.branch_taken), 64'(out_data.branch_taken));
			check_field("branch_target", e.branch_target, out_data.branch_target);
			if (d.op <= ex_pkg::op_subw && first_seen != acc + 1) begin
				errors++;
				$display("ALU item accepted in cycle %0d appeared in cycle %0d, not one later",
					acc, first_seen);
			end
			checked++;
		end
	endtask

	// sample one time unit after the falling edge
	always @(negedge clk) begin
		#1;
		if (!reset) begin
			sample = sample + 1;
			if (out_valid && !shown) begin
				shown = 1'b1;
				first_seen = sample;
				unit_wait = 1'b0;
			end
			if (held && !(out_valid && out_data === held_data)) begin
				errors++;
				$display("out_data changed or out_valid dropped while out_ready was low");
			end
			if (unit_wait && in_ready) begin
				errors++;
				$display("in_ready rose before the multiply or divide result was presented");
			end
			if (out_valid && out_ready) begin
				check_output();
				shown = 1'b0;
			end
			held = out_valid && !out_ready;
			held_data = out_data;
			if (in_valid && in_ready) begin
				exp_q.push_back(in_data);
				acc_q.push_back(sample);
				unit_wait = in_data.op >= ex_pkg::op_mul;
			end
		end
	end

	// called on a falling edge, returns on the falling edge after acceptance
	task automatic send_item(input ex_pkg::ex_in_t d);
		in_valid = 1'b1;
		in_data = d;
		#1;
		while (!in_ready) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	initial begin
		#(n_items * 70 * clk_period + 20 * clk_period);
		$display("timeout: the item stream did not complete in time");
		$display("Regression failed");
		$finish;
	end

	initial begin
		int             i;
		logic           word;
		ex_pkg::ex_in_t d;
		void'($urandom(85));
		for (i = 0; i < 1024; i++)
			ready_pattern[i] = ($urandom % 3) != 0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_data = '0;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		if (out_valid !== 1'b0) begin
			errors++;
			$display("out_valid was high after reset before any item was sent");
		end
		for (i = 0; i < n_alu; i++)
			send_item(make_item(ex_pkg::alu_op_t'(5'($urandom % 19))));
		for (i = 0; i < n_mul; i++)
			send_item(make_item(ex_pkg::alu_op_t'(5'(19 + i % 4))));
		for (i = 0; i < 8; i++) begin // zero divisor, then signed overflow
			d = make_item(ex_pkg::alu_op_t'(5'(23 + i)));
			word = d.op inside {ex_pkg::op_divw, ex_pkg::op_divuw, ex_pkg::op_remuw,
				ex_pkg::op_remw};
			d.src_b = word ? {$urandom, 32'd0} : 64'd0;
			send_item(d);
			if (d.op inside {ex_pkg::op_div, ex_pkg::op_divw, ex_pkg::op_rem, ex_pkg::op_remw}) begin
				d.src_a = word ? {$urandom, 32'h8000_0000} : 64'h8000_0000_0000_0000;
				d.src_b = word ? {$urandom, 32'hffff_ffff} : '1;
				send_item(d);
			end
		end
		for (i = 0; i < n_div - 12; i++)
			send_item(make_item(ex_pkg::alu_op_t'(5'(23 + i % 8))));
		for (i = 0; i < n_branch; i++) begin
			d = make_item(ex_pkg::alu_op_t'(5'(11 + i % 6))); // compare ops
			d.is_branch = 1'b1;
			if (i % 2 == 0)
				d.src_b = d.src_a;
			send_item(d);
		end
		ready_random = 1'b1;
		for (i = 0; i < n_mixed; i++)
			send_item(make_item(ex_pkg::alu_op_t'(5'($urandom % 31))));
		for (i = 0; i < 400 && exp_q.size() != 0; i++)
			@(negedge clk);
		ready_random = 1'b0;
		repeat (4) @(negedge clk);
		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d accepted items never came out", exp_q.size());
		end
		$display("%0d items checked, %0d errors", checked, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* build.f */
+incdir+testbench
source/ex_pkg.sv
source/ex_alu.sv
source/ex_mul_unit.sv
source/ex_div_unit.sv
source/ex_sequencer.sv
source/ex_stage.sv
testbench/ex_stage_tb.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - source/ex_pkg.sv
  - source/ex_alu.sv
  - source/ex_mul_unit.sv
  - source/ex_div_unit.sv
  - source/ex_sequencer.sv
  - source/ex_stage.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/ex_stage_tb.sv
